//--- verilog.f
common/esaxi_pkg.sv
axi_write/axi_write_ctrl.sv
axi_write/emesh_write_packer.sv
axi_read/axi_read_ctrl.sv
axi_read/read_responder.sv
hdl/mi_decoder.sv
hdl/esaxi.sv
sim/esaxi_tb.sv

//--- Makefile
# Verilator build and run for the esaxi bridge

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= esaxi_tb
RTL_TOP   ?= esaxi
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Checks failed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "All checks passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) \
		$(filter-out sim/%,$(shell cat $(FILELIST)))

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/esaxi_tb.sv
`timescale 1ns/1ps

module esaxi_tb;
   import esaxi_pkg::*;

   localparam int          axi_addr_width = 30;
   localparam logic [11:0] elink_id       = 12'h810;
   localparam logic [11:0] core_id        = 12'h808;  // upper bits 2'b10
   localparam logic [3:0]  tx_ctrl        = 4'h5;
   localparam int          max_len        = 8;   // beats per burst
   localparam int          max_delay      = 6;   // network response delay
   localparam int          n_trans        = 33;  // transactions over all tests
   localparam int          cycle_limit    = n_trans * (max_len * (max_delay + 16) + 50);

   logic        s_axi_aclk;
   logic        s_axi_aresetn;
   logic [29:0] awaddr, araddr;
   logic [7:0]  awlen, arlen;
   logic [1:0]  awburst, arburst;
   logic [2:0]  awsize, arsize;
   logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic [1:0]  bresp, rresp;
   logic        arvalid, arready, rvalid, rready, rlast;
   logic [31:0] rdata;
   logic        emwr_access, emwr_progfull, emrq_access, emrr_access, emrr_rd_en;
   logic [31:0] emrr_data;
   emesh_pkt_t  emwr_pkt, emrq_pkt;
   mi_req_t     mi_req;
   mi_sel_t     mi_sel;
   mi_dout_t    mi_dout;

   int          checks;
   int          errors;
   int          cycles;
   bit          pf_on;        // random back-pressure enable
   bit          mi_pend_exp;  // register read pending this cycle

   emesh_pkt_t  wr_pkt_q[$];   // packets seen on the write side
   mi_sel_t     wr_sel_q[$];
   mi_req_t     wr_req_q[$];
   logic [31:0] rq_addr_q[$];  // read request addresses
   logic [5:0]  rq_mode_q[$];  // datamode and ctrlmode per request
   logic [31:0] rsp_q[$];      // network response words

   esaxi #(.axi_addr_width(axi_addr_width), .elink_id(elink_id)) esaxi_inst (
      .s_axi_aclk, .s_axi_aresetn,
      .s_axi_awaddr(awaddr), .s_axi_awlen(awlen), .s_axi_awburst(awburst),
      .s_axi_awsize(awsize), .s_axi_awvalid(awvalid), .s_axi_awready(awready),
      .s_axi_wdata(wdata), .s_axi_wstrb(wstrb), .s_axi_wlast(wlast),
      .s_axi_wvalid(wvalid), .s_axi_wready(wready),
      .s_axi_bresp(bresp), .s_axi_bvalid(bvalid), .s_axi_bready(bready),
      .s_axi_araddr(araddr), .s_axi_arlen(arlen), .s_axi_arburst(arburst),
      .s_axi_arsize(arsize), .s_axi_arvalid(arvalid), .s_axi_arready(arready),
      .s_axi_rdata(rdata), .s_axi_rresp(rresp), .s_axi_rlast(rlast),
      .s_axi_rvalid(rvalid), .s_axi_rready(rready),
      .emwr_access, .emwr_pkt, .emwr_progfull, .emrq_access, .emrq_pkt,
      .emrr_access, .emrr_data, .emrr_rd_en,
      .mi_req, .mi_sel, .mi_dout,
      .ecfg_tx_ctrlmode(tx_ctrl), .ecfg_coreid(core_id));

   // ##############################
   // clock, watchdog, monitors
   // ##############################
   initial
   begin
      s_axi_aclk = 1'b0;
      forever #10 s_axi_aclk = ~s_axi_aclk;  // 20 ns period
   end

   always @(posedge s_axi_aclk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("timeout after %0d cycles, a DUT handshake never completed", cycles);
         $display("Checks failed");
         $finish;
      end
   end

   // everything sampled at the rising edge, inputs move on the falling one
   always @(posedge s_axi_aclk)
   begin
      if (s_axi_aresetn && emwr_access)
      begin
         wr_pkt_q.push_back(emwr_pkt);
         wr_sel_q.push_back(mi_sel);   // mi outputs valid with the packet
         wr_req_q.push_back(mi_req);
      end
      if (s_axi_aresetn)
         check_value("rd_en", {31'd0, emrr_access & ~mi_pend_exp}, {31'd0, emrr_rd_en});
      // local read request makes the next cycle pending
      mi_pend_exp <= s_axi_aresetn && emrq_access
                     && (emrq_pkt.dstaddr.f.link_id == elink_id);
   end

   // back-pressure source
   initial
   begin
      emwr_progfull = 1'b0;
      forever
      begin
         @(negedge s_axi_aclk);
         emwr_progfull = pf_on ? 1'($urandom_range(0, 1)) : 1'b0;
      end
   end

   // network side, answers each remote request after a random delay
   initial
   begin
      int delay;
      emrr_access = 1'b0;
      emrr_data   = '0;
      forever
      begin
         @(posedge s_axi_aclk);
         if (s_axi_aresetn && emrq_access)
         begin
            rq_addr_q.push_back(emrq_pkt.dstaddr.flat);
            rq_mode_q.push_back({emrq_pkt.datamode, emrq_pkt.ctrlmode});
            if (emrq_pkt.dstaddr.f.link_id != elink_id)  // local ones go to mi
            begin
               delay = $urandom_range(0, max_delay);
               repeat (delay) @(posedge s_axi_aclk);
               @(negedge s_axi_aclk);
               emrr_data   = $urandom;
               emrr_access = 1'b1;
               rsp_q.push_back(emrr_data);
               @(negedge s_axi_aclk);
               emrr_access = 1'b0;
            end
            else
            begin
               // stray network word while the register read is pending
               @(negedge s_axi_aclk);
               emrr_data   = $urandom;
               emrr_access = 1'b1;
               @(negedge s_axi_aclk);
               emrr_access = 1'b0;
            end
         end
      end
   end

   // ##############################
   // model helpers
   // ##############################
   task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
      checks++;
      assert (exp === act)
      else
      begin
         $display("Fail %s: expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   function automatic int lowest_lane(logic [3:0] strb);
      int lane;
      lane = 3;
      for (int i = 3; i >= 0; i--)
         if (strb[i])
            lane = i;
      return lane;
   endfunction

   function automatic logic [31:0] replicate_by_size(logic [31:0] d, logic [2:0] size);
      if (size == 3'd0)
         return {4{d[7:0]}};
      else if (size == 3'd1)
         return {2{d[15:0]}};
      return d;
   endfunction

   function automatic logic [3:0] sel_for_group(logic [3:0] g);  // {ecfg,rx,tx,embox}
      case (g)
         group_mmr:   return 4'b1000;
         group_rxmmu: return 4'b0100;
         group_txmmu: return 4'b0010;
         group_embox: return 4'b0001;
         default:     return 4'b0000;
      endcase
   endfunction

   function automatic logic [31:0] word_for_group(logic [3:0] g);
      case (g)
         group_mmr:   return mi_dout.ecfg;
         group_rxmmu: return mi_dout.rx_emmu;
         group_txmmu: return mi_dout.tx_emmu;
         default:     return mi_dout.embox;
      endcase
   endfunction

   function automatic logic [29:0] remote_addr();
      logic [29:0] a;
      a = 30'($urandom);
      while (a[29:20] == elink_id[9:0])  // keep away from our link id
         a = 30'($urandom);
      return a;
   endfunction

   function automatic logic [29:0] local_addr(logic [3:0] g);
      return {elink_id[9:0], g, 16'($urandom_range(0, 16'hff00))};
   endfunction

   // ##############################
   // write and read drivers
   // ##############################
   task automatic run_write(string name, logic [29:0] addr, int len, logic [1:0] burst,
                            logic [2:0] size, bit full_strb, bit use_pf);
      logic [31:0] cur;
      emesh_pkt_t  exp_q[$];
      emesh_pkt_t  e;
      bit          local_hit;
      int          ofs;
      cur = {core_id[11:10], addr};
      wr_pkt_q.delete();
      wr_sel_q.delete();
      wr_req_q.delete();
      @(negedge s_axi_aclk);
      awaddr  = addr;
      awlen   = 8'(len);
      awburst = burst;
      awsize  = size;
      awvalid = 1'b1;
      do @(posedge s_axi_aclk); while (!awready);
      @(negedge s_axi_aclk);
      awvalid = 1'b0;
      pf_on   = use_pf;
      for (int i = 0; i <= len; i++)
      begin
         wdata  = $urandom;
         wstrb  = full_strb ? 4'hf : 4'($urandom_range(1, 15));
         wlast  = (i == len);
         wvalid = 1'b1;
         do @(posedge s_axi_aclk); while (!wready);
         ofs = lowest_lane(wstrb);
         e.dstaddr.flat = {cur[31:2], 2'(ofs)};
         e.data         = wdata >> (8 * ofs);  // aligned to lane zero
         e.datamode     = size[1:0];
         e.ctrlmode     = tx_ctrl;
         exp_q.push_back(e);
         if (burst == burst_incr)
            cur = {cur[31:2] + 30'd1, 2'b00};
         @(negedge s_axi_aclk);
      end
      wvalid = 1'b0;
      pf_on  = 1'b0;
      bready = 1'b1;
      do @(posedge s_axi_aclk); while (!bvalid);
      check_value({name, " bresp"}, {30'd0, resp_okay}, {30'd0, bresp});
      @(negedge s_axi_aclk);
      bready = 1'b0;
      while (wr_pkt_q.size() < exp_q.size())
         @(posedge s_axi_aclk);
      repeat (3) @(posedge s_axi_aclk);  // room for stray packets
      check_value({name, " count"}, exp_q.size(), wr_pkt_q.size());
      for (int i = 0; i < exp_q.size() && i < wr_pkt_q.size(); i++)
      begin
         local_hit = (exp_q[i].dstaddr.f.link_id == elink_id);
         check_value({name, " dstaddr"}, exp_q[i].dstaddr.flat, wr_pkt_q[i].dstaddr.flat);
         check_value({name, " data"}, exp_q[i].data, wr_pkt_q[i].data);
         check_value({name, " datamode"}, exp_q[i].datamode, wr_pkt_q[i].datamode);
         check_value({name, " ctrlmode"}, exp_q[i].ctrlmode, wr_pkt_q[i].ctrlmode);
         check_value({name, " mi_sel"},
                     local_hit ? sel_for_group(exp_q[i].dstaddr.f.group) : 4'b0000,
                     wr_sel_q[i]);
         check_value({name, " mi_we"}, local_hit, wr_req_q[i].we);
         if (local_hit)
         begin
            check_value({name, " mi_addr"}, exp_q[i].dstaddr.flat[19:0], wr_req_q[i].addr);
            check_value({name, " mi_din"}, exp_q[i].data, wr_req_q[i].din);
         end
      end
   endtask

   task automatic run_read(string name, logic [29:0] addr, int len, logic [1:0] burst,
                           logic [2:0] size);
      logic [31:0] cur;
      logic [31:0] exp_addr_q[$];
      logic [31:0] word;
      bit          local_hit;
      cur = {core_id[11:10], addr};
      local_hit = (cur[31:20] == elink_id);
      rq_addr_q.delete();
      rq_mode_q.delete();
      rsp_q.delete();
      @(negedge s_axi_aclk);
      araddr  = addr;
      arlen   = 8'(len);
      arburst = burst;
      arsize  = size;
      arvalid = 1'b1;
      rready  = 1'b1;
      do @(posedge s_axi_aclk); while (!arready);
      @(negedge s_axi_aclk);
      arvalid = 1'b0;
      for (int i = 0; i <= len; i++)
      begin
         do @(posedge s_axi_aclk); while (!rvalid);
         exp_addr_q.push_back(cur);
         if (local_hit)
            word = word_for_group(cur[19:16]);
         else
         begin
            checks++;
            assert (rsp_q.size() > 0)
            else
            begin
               $display("%s: read data came back with no network response behind it", name);
               errors++;
            end
            word = 'x;
            if (rsp_q.size() > 0)
               word = rsp_q.pop_front();
         end
         check_value({name, " rdata"}, replicate_by_size(word, size), rdata);
         check_value({name, " rresp"}, {30'd0, resp_okay}, {30'd0, rresp});
         check_value({name, " rlast"}, (i == len), rlast);
         if (burst == burst_incr)
            cur = {cur[31:2] + 30'd1, 2'b00};
      end
      repeat (3) @(posedge s_axi_aclk);
      check_value({name, " requests"}, exp_addr_q.size(), rq_addr_q.size());
      for (int i = 0; i < exp_addr_q.size() && i < rq_addr_q.size(); i++)
      begin
         check_value({name, " rq_addr"}, exp_addr_q[i], rq_addr_q[i]);
         check_value({name, " rq_mode"}, {size[1:0], tx_ctrl}, rq_mode_q[i]);
      end
   endtask

   task automatic report_test(string name, int err_before);
      $display("test %s: %s (%0d errors)", name,
               (errors == err_before) ? "ok" : "failed", errors - err_before);
   endtask

   // ##############################
   // test sequence
   // ##############################
   initial
   begin
      int       e0;
      logic [3:0] grp [4];
      void'($urandom(32'hb38a_97e1));
      checks  = 0;
      errors  = 0;
      cycles  = 0;
      pf_on   = 1'b0;
      s_axi_aresetn = 1'b0;
      {awaddr, awlen, awburst, awsize, awvalid} = '0;
      {wdata, wstrb, wlast, wvalid, bready} = '0;
      {araddr, arlen, arburst, arsize, arvalid, rready} = '0;
      mi_dout = {32'($urandom), 32'($urandom), 32'($urandom), 32'($urandom)};
      grp = '{group_mmr, group_rxmmu, group_txmmu, group_embox};
      repeat (4) @(posedge s_axi_aclk);
      @(negedge s_axi_aclk);
      s_axi_aresetn = 1'b1;

      e0 = errors;
      run_write("single_write", remote_addr(), 0, burst_incr, 3'd2, 1'b1, 1'b0);
      report_test("single_write", e0);

      e0 = errors;
      for (int i = 0; i < 8; i++)
         run_write("partial_strobe", remote_addr(), 0, burst_incr, 3'd2, 1'b0, 1'b0);
      report_test("partial_strobe", e0);

      e0 = errors;
      for (int i = 0; i < 8; i++)
         run_write("write_burst", remote_addr(), $urandom_range(0, max_len - 1),
                   2'($urandom_range(0, 1)), 3'd2, 1'b0, 1'b1);
      report_test("write_burst", e0);

      e0 = errors;
      for (int i = 0; i < 8; i++)
         run_read("network_read", remote_addr(), $urandom_range(0, max_len - 1),
                  2'($urandom_range(0, 1)), 3'($urandom_range(0, 2)));
      report_test("network_read", e0);

      e0 = errors;
      for (int i = 0; i < 4; i++)  // every block once each way
      begin
         run_write("local_write", local_addr(grp[i]), 0, burst_incr, 3'd2, 1'b1, 1'b0);
         run_read("local_read", local_addr(grp[i]), $urandom_range(0, 3),
                  2'($urandom_range(0, 1)), 3'($urandom_range(0, 2)));
      end
      report_test("local_access", e0);

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

//--- hdl/esaxi.sv
`timescale 1ns/1ps

module esaxi #(
   parameter int          axi_addr_width = 30,
   parameter logic [11:0] elink_id       = 12'h810
) (
   input  logic                      s_axi_aclk,
   input  logic                      s_axi_aresetn,
   // axi write address
   input  logic [axi_addr_width-1:0] s_axi_awaddr,
   input  logic [7:0]                s_axi_awlen,
   input  logic [1:0]                s_axi_awburst,
   input  logic [2:0]                s_axi_awsize,
   input  logic                      s_axi_awvalid,
   output logic                      s_axi_awready,
   // axi write data and response
   input  logic [31:0]               s_axi_wdata,
   input  logic [3:0]                s_axi_wstrb,
   input  logic                      s_axi_wlast,
   input  logic                      s_axi_wvalid,
   output logic                      s_axi_wready,
   output logic [1:0]                s_axi_bresp,
   output logic                      s_axi_bvalid,
   input  logic                      s_axi_bready,
   // axi read address and data
   input  logic [axi_addr_width-1:0] s_axi_araddr,
   input  logic [7:0]                s_axi_arlen,
   input  logic [1:0]                s_axi_arburst,
   input  logic [2:0]                s_axi_arsize,
   input  logic                      s_axi_arvalid,
   output logic                      s_axi_arready,
   output logic [31:0]               s_axi_rdata,
   output logic [1:0]                s_axi_rresp,
   output logic                      s_axi_rlast,
   output logic                      s_axi_rvalid,
   input  logic                      s_axi_rready,
   // emesh link
   output logic                      emwr_access,
   output esaxi_pkg::emesh_pkt_t     emwr_pkt,
   input  logic                      emwr_progfull,
   output logic                      emrq_access,
   output esaxi_pkg::emesh_pkt_t     emrq_pkt,
   input  logic                      emrr_access,
   input  logic [31:0]               emrr_data,
   output logic                      emrr_rd_en,
   // register bus and config
   output esaxi_pkg::mi_req_t        mi_req,
   output esaxi_pkg::mi_sel_t        mi_sel,
   input  esaxi_pkg::mi_dout_t       mi_dout,
   input  logic [3:0]                ecfg_tx_ctrlmode,
   input  logic [11:0]               ecfg_coreid
);
   import esaxi_pkg::*;

   axi_addr_t   aw;
   axi_addr_t   ar;
   axi_wbeat_t  w;
   axi_wbeat_t  beat;
   axi_addr_t   wr_cur;
   logic        beat_fire;
   logic [2:0]  rd_size;
   logic        mi_rd_pending;
   logic [31:0] mi_rdata;

   // address bits above the axi width come from the core id later
   assign aw = '{addr: {{(32-axi_addr_width){1'b0}}, s_axi_awaddr}, len: s_axi_awlen,
                 burst: s_axi_awburst, size: s_axi_awsize};
   assign ar = '{addr: {{(32-axi_addr_width){1'b0}}, s_axi_araddr}, len: s_axi_arlen,
                 burst: s_axi_arburst, size: s_axi_arsize};
   assign w  = '{data: s_axi_wdata, strb: s_axi_wstrb, last: s_axi_wlast};

   axi_write_ctrl #(.axi_addr_width(axi_addr_width)) axi_write_ctrl_inst (
      .s_axi_aclk, .s_axi_aresetn, .ecfg_coreid,
      .awvalid(s_axi_awvalid), .aw, .awready(s_axi_awready),
      .wvalid(s_axi_wvalid), .w, .wready(s_axi_wready),
      .bvalid(s_axi_bvalid), .bresp(s_axi_bresp), .bready(s_axi_bready),
      .emwr_progfull, .beat_fire, .beat, .cur(wr_cur));

   emesh_write_packer emesh_write_packer_inst (
      .s_axi_aclk, .s_axi_aresetn, .ecfg_tx_ctrlmode,
      .beat_fire, .beat, .cur(wr_cur), .emwr_access, .emwr_pkt);

   axi_read_ctrl #(.axi_addr_width(axi_addr_width)) axi_read_ctrl_inst (
      .s_axi_aclk, .s_axi_aresetn, .ecfg_coreid, .ecfg_tx_ctrlmode,
      .arvalid(s_axi_arvalid), .ar, .arready(s_axi_arready),
      .rvalid(s_axi_rvalid), .rready(s_axi_rready), .rlast(s_axi_rlast),
      .emrq_access, .emrq_pkt, .size(rd_size));

   read_responder read_responder_inst (
      .s_axi_aclk, .s_axi_aresetn, .size(rd_size),
      .emrr_access, .emrr_data, .mi_rd_pending, .mi_rdata,
      .rready(s_axi_rready), .rvalid(s_axi_rvalid), .rdata(s_axi_rdata),
      .rresp(s_axi_rresp), .emrr_rd_en);

   mi_decoder #(.elink_id(elink_id)) mi_decoder_inst (
      .s_axi_aclk, .emwr_access, .emwr_pkt, .emrq_access, .emrq_pkt,
      .mi_dout, .mi_req, .mi_sel, .mi_rd_pending, .mi_rdata);

endmodule

//--- hdl/mi_decoder.sv
`timescale 1ns/1ps

module mi_decoder #(
   parameter logic [11:0] elink_id = 12'h810
) (
   input  logic                  s_axi_aclk,
   input  logic                  emwr_access,
   input  esaxi_pkg::emesh_pkt_t emwr_pkt,
   input  logic                  emrq_access,
   input  esaxi_pkg::emesh_pkt_t emrq_pkt,
   input  esaxi_pkg::mi_dout_t   mi_dout,
   output esaxi_pkg::mi_req_t    mi_req,
   output esaxi_pkg::mi_sel_t    mi_sel,
   output logic                  mi_rd_pending,
   output logic [31:0]           mi_rdata
);
   import esaxi_pkg::*;

   logic       mi_wr;
   logic       mi_rd;
   logic       mi_en;
   logic [3:0] grp;
   mi_sel_t    sel_q;  // selects of the last access

   // local when the link id is ours
   assign mi_wr = emwr_access & (emwr_pkt.dstaddr.f.link_id == elink_id);
   assign mi_rd = emrq_access & (emrq_pkt.dstaddr.f.link_id == elink_id);
   assign mi_en = mi_wr | mi_rd;

   // write has the address when both fire
   assign grp         = mi_wr ? emwr_pkt.dstaddr.f.group : emrq_pkt.dstaddr.f.group;
   assign mi_req.we   = mi_wr;
   assign mi_req.addr = mi_wr ? emwr_pkt.dstaddr.flat[19:0] : emrq_pkt.dstaddr.flat[19:0];
   assign mi_req.din  = emwr_pkt.data;

   assign mi_sel.ecfg    = mi_en & (grp == group_mmr);
   assign mi_sel.rx_emmu = mi_en & (grp == group_rxmmu);
   assign mi_sel.tx_emmu = mi_en & (grp == group_txmmu);
   assign mi_sel.embox   = mi_en & (grp == group_embox);

   // ############################
   // readback
   // ############################
   always_ff @(posedge s_axi_aclk)
   begin
      sel_q         <= mi_sel;
      mi_rd_pending <= mi_rd;
   end

   // embox is the fall-through
   assign mi_rdata = sel_q.ecfg    ? mi_dout.ecfg    :
                     sel_q.rx_emmu ? mi_dout.rx_emmu :
                     sel_q.tx_emmu ? mi_dout.tx_emmu :
                                     mi_dout.embox;

endmodule

//--- axi_read/read_responder.sv
`timescale 1ns/1ps

module read_responder (
   input  logic        s_axi_aclk,
   input  logic        s_axi_aresetn,
   input  logic [2:0]  size,
   input  logic        emrr_access,
   input  logic [31:0] emrr_data,
   input  logic        mi_rd_pending,
   input  logic [31:0] mi_rdata,
   input  logic        rready,
   output logic        rvalid,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        emrr_rd_en
);
   import esaxi_pkg::*;

   logic [31:0] mux_data;
   logic        resp_in;  // a response word arrives

   // register readback wins over the network
   assign mux_data   = mi_rd_pending ? mi_rdata : emrr_data;
   assign resp_in    = emrr_access | mi_rd_pending;
   assign emrr_rd_en = emrr_access & ~mi_rd_pending;  // pop rx only for network data
   assign rresp      = resp_okay;

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         rvalid <= 1'b0;
      else if (resp_in)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;  // held until taken
   end

   // replicate narrow data over all lanes
   always_ff @(posedge s_axi_aclk)
   begin
      if (resp_in)
      begin
         case (size)
            3'd0:    rdata <= {4{mux_data[7:0]}};   // byte
            3'd1:    rdata <= {2{mux_data[15:0]}};  // half
            default: rdata <= mux_data;
         endcase
      end
   end

endmodule

//--- axi_read/axi_read_ctrl.sv
`timescale 1ns/1ps

module axi_read_ctrl #(
   parameter int axi_addr_width = 30
) (
   input  logic                  s_axi_aclk,
   input  logic                  s_axi_aresetn,
   input  logic [11:0]           ecfg_coreid,
   input  logic [3:0]            ecfg_tx_ctrlmode,
   input  logic                  arvalid,
   input  esaxi_pkg::axi_addr_t  ar,
   output logic                  arready,
   input  logic                  rvalid,
   input  logic                  rready,
   output logic                  rlast,
   output logic                  emrq_access,
   output esaxi_pkg::emesh_pkt_t emrq_pkt,
   output logic [2:0]            size
);
   import esaxi_pkg::*;

   axi_addr_t cur;           // live burst state
   logic      read_active;
   logic      ractive_q;     // for the leading edge
   logic      rnext;         // non-last beat taken
   logic      beat_taken;
   logic      last_rd_beat;

   assign beat_taken   = rvalid & rready;
   assign last_rd_beat = beat_taken & rlast;
   assign size         = cur.size;

   // ############################
   // address channel
   // ############################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         arready     <= 1'b0;
         read_active <= 1'b0;
         rlast       <= 1'b0;
      end
      else
      begin
         // one burst at a time
         if (!arready && (!read_active || last_rd_beat))
            arready <= 1'b1;
         else if (arvalid && arready)
            arready <= 1'b0;

         if (arvalid && arready)
            read_active <= 1'b1;
         else if (last_rd_beat)
            read_active <= 1'b0;

         if (arvalid && arready)
            rlast <= (ar.len == 8'd0);  // single beat
         else if (beat_taken && cur.len == 8'd1)
            rlast <= 1'b1;
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (arvalid && arready)
      begin
         cur.addr  <= {ecfg_coreid[11:axi_addr_width-20], ar.addr[axi_addr_width-1:0]};
         cur.len   <= ar.len;
         cur.burst <= ar.burst;
         cur.size  <= ar.size;
      end
      else if (beat_taken)
      begin
         cur.len <= cur.len - 1'b1;
         if (cur.burst == burst_incr)  // captured type, not the live one
         begin
            cur.addr[31:addr_lsb]  <= cur.addr[31:addr_lsb] + 1'b1;
            cur.addr[addr_lsb-1:0] <= '0;
         end
      end
   end

   // ############################
   // emesh read requests
   // ############################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         ractive_q   <= 1'b0;
         rnext       <= 1'b0;
         emrq_access <= 1'b0;
      end
      else
      begin
         ractive_q   <= read_active;
         rnext       <= beat_taken & ~rlast;
         emrq_access <= (read_active & ~ractive_q) | rnext;
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      emrq_pkt.dstaddr.flat <= cur.addr;
      emrq_pkt.data         <= '0;  // requests carry no payload
      emrq_pkt.datamode     <= cur.size[1:0];
      emrq_pkt.ctrlmode     <= ecfg_tx_ctrlmode;
   end

endmodule

//--- axi_write/emesh_write_packer.sv
`timescale 1ns/1ps

module emesh_write_packer (
   input  logic                  s_axi_aclk,
   input  logic                  s_axi_aresetn,
   input  logic [3:0]            ecfg_tx_ctrlmode,
   input  logic                  beat_fire,
   input  esaxi_pkg::axi_wbeat_t beat,
   input  esaxi_pkg::axi_addr_t  cur,
   output logic                  emwr_access,
   output esaxi_pkg::emesh_pkt_t emwr_pkt
);
   import esaxi_pkg::*;

   logic       s1_access;
   emesh_pkt_t s1_pkt;
   logic [1:0] ofs;  // lowest enabled byte lane

   always_comb
   begin
      casez (beat.strb)
         4'b???1: ofs = 2'd0;  // aligned
         4'b??10: ofs = 2'd1;
         4'b?100: ofs = 2'd2;
         default: ofs = 2'd3;
      endcase
   end

   // ############################
   // two stage packet pipe
   // ############################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s1_access   <= 1'b0;
         emwr_access <= 1'b0;
      end
      else
      begin
         s1_access   <= beat_fire;
         emwr_access <= s1_access;
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      // stage 1, align data to lane zero
      s1_pkt.dstaddr.flat <= {cur.addr[31:addr_lsb], ofs};
      s1_pkt.data         <= beat.data >> {ofs, 3'b000};
      s1_pkt.datamode     <= cur.size[1:0];
      s1_pkt.ctrlmode     <= ecfg_tx_ctrlmode;
      // stage 2
      emwr_pkt            <= s1_pkt;
   end

endmodule

//--- axi_write/axi_write_ctrl.sv
`timescale 1ns/1ps

module axi_write_ctrl #(
   parameter int axi_addr_width = 30
) (
   input  logic                  s_axi_aclk,
   input  logic                  s_axi_aresetn,
   input  logic [11:0]           ecfg_coreid,
   input  logic                  awvalid,
   input  esaxi_pkg::axi_addr_t  aw,
   output logic                  awready,
   input  logic                  wvalid,
   input  esaxi_pkg::axi_wbeat_t w,
   output logic                  wready,
   output logic                  bvalid,
   output logic [1:0]            bresp,
   input  logic                  bready,
   input  logic                  emwr_progfull,
   output logic                  beat_fire,
   output esaxi_pkg::axi_wbeat_t beat,
   output esaxi_pkg::axi_addr_t  cur
);
   import esaxi_pkg::*;

   logic write_active;  // address taken, beats still due
   logic last_beat;

   assign beat_fire = wvalid & wready;
   assign last_beat = beat_fire & w.last;
   assign beat      = w;          // packer samples on beat_fire
   assign bresp     = resp_okay;  // no error paths

   // ############################
   // address channel
   // ############################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         awready      <= 1'b0;
         write_active <= 1'b0;
      end
      else
      begin
         // ready again once the response has gone
         if (!awready && !write_active && (!bvalid || bready))
            awready <= 1'b1;
         else if (awvalid && awready)
            awready <= 1'b0;

         if (awvalid && awready)
            write_active <= 1'b1;
         else if (last_beat)
            write_active <= 1'b0;
      end
   end

   // captured address, stepped per beat
   always_ff @(posedge s_axi_aclk)
   begin
      if (awvalid && awready)
      begin
         cur.addr  <= {ecfg_coreid[11:axi_addr_width-20], aw.addr[axi_addr_width-1:0]};
         cur.len   <= aw.len;
         cur.burst <= aw.burst;
         cur.size  <= aw.size;
      end
      else if (beat_fire && cur.burst == burst_incr)
      begin
         cur.addr[31:addr_lsb]   <= cur.addr[31:addr_lsb] + 1'b1;  // next word
         cur.addr[addr_lsb-1:0]  <= '0;
      end
      // fixed and wrap hold the address
   end

   // ############################
   // data and response channels
   // ############################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         wready <= 1'b0;
         bvalid <= 1'b0;
      end
      else
      begin
         if (last_beat)
            wready <= 1'b0;
         else if (write_active)
            wready <= ~emwr_progfull;  // one beat may still slip in

         if (last_beat)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
      end
   end

endmodule

//--- common/esaxi_pkg.sv
package esaxi_pkg;

   // ############################
   // widths and codes
   // ############################
   localparam int data_w   = 32;  // axi and emesh data
   localparam int addr_lsb = 2;   // byte offset bits in a word

   localparam logic [1:0] burst_incr = 2'b01;
   localparam logic [1:0] resp_okay  = 2'b00;

   // register bus block groups, address bits [19:16]
   localparam logic [3:0] group_mmr   = 4'hf;
   localparam logic [3:0] group_rxmmu = 4'he;
   localparam logic [3:0] group_txmmu = 4'hd;
   localparam logic [3:0] group_embox = 4'hc;

   // ############################
   // bus structs
   // ############################
   typedef struct packed {
      logic [31:0] addr;
      logic [7:0]  len;    // beats minus one
      logic [1:0]  burst;  // 0 fixed, 1 incr, 2 wrap
      logic [2:0]  size;   // 0 byte, 1 half, 2 word
   } axi_addr_t;

   typedef struct packed {
      logic [data_w-1:0]   data;
      logic [data_w/8-1:0] strb;
      logic                last;
   } axi_wbeat_t;

   // same word, flat or split into link id, group and offset
   typedef union packed {
      logic [31:0] flat;
      struct packed {
         logic [11:0] link_id;
         logic [3:0]  group;
         logic [15:0] offset;
      } f;
   } emesh_addr_u;

   typedef struct packed {
      emesh_addr_u       dstaddr;
      logic [data_w-1:0] data;
      logic [1:0]        datamode;  // log2 of bytes
      logic [3:0]        ctrlmode;
   } emesh_pkt_t;

   typedef struct packed {
      logic ecfg;
      logic rx_emmu;
      logic tx_emmu;
      logic embox;
   } mi_sel_t;

   typedef struct packed {
      logic              we;
      logic [19:0]       addr;
      logic [data_w-1:0] din;
   } mi_req_t;

   typedef struct packed {
      logic [data_w-1:0] ecfg;
      logic [data_w-1:0] rx_emmu;
      logic [data_w-1:0] tx_emmu;
      logic [data_w-1:0] embox;
   } mi_dout_t;

endpackage
